// ==== axi_sram_pkg.sv ====
package axi_sram_pkg;

  // AXI side of the bridge
  localparam int axi_addr_width = 12;
  localparam int axi_data_width = 16;
  localparam int axi_strb_width = axi_data_width / 8;
  localparam int axi_id_width = 4;

  // Byte address bits below one data word
  localparam int word_lsb = $clog2(axi_strb_width);

  // The SRAM side holds one entry per data word
  localparam int sram_addr_width = axi_addr_width - word_lsb;
  localparam int mem_depth = 1 << sram_addr_width;

  // Every B and R beat reports OKAY
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

// ==== sram_cmd_if.sv ====
// Reads and writes share this channel with one command per word
interface sram_cmd_if import axi_sram_pkg::*; ();

  logic                       valid;
  logic                       ready;
  logic                       wr_en;
  logic [sram_addr_width-1:0] addr;
  logic [axi_id_width-1:0]    meta;
  logic                       last;
  logic [axi_data_width-1:0]  wr_data;
  logic [axi_strb_width-1:0]  wr_strb;

  modport initiator (
    output valid, wr_en, addr, meta, last, wr_data, wr_strb,
    input  ready
  );

  modport target (
    input  valid, wr_en, addr, meta, last, wr_data, wr_strb,
    output ready
  );

endinterface

// Read data returned by the memory, tagged with the command's meta and last
interface sram_rsp_if import axi_sram_pkg::*; ();

  logic                      valid;
  logic                      ready;
  logic [axi_data_width-1:0] data;
  logic [axi_id_width-1:0]   meta;
  logic                      last;

  modport source (output valid, data, meta, last, input ready);

  modport sink (input valid, data, meta, last, output ready);

endinterface

// ==== axi_sram_wr.sv ====
module axi_sram_wr import axi_sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      awvalid,
  input  logic [axi_id_width-1:0]   awid,
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic [7:0]                awlen,
  output logic                      awready,

  input  logic                      wvalid,
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  input  logic                      wlast,
  output logic                      wready,

  output logic                      bvalid,
  output logic [axi_id_width-1:0]   bid,
  output logic [1:0]                bresp,
  input  logic                      bready,

  sram_cmd_if.initiator             cmd
);

  enum logic [1:0] {st_idle, st_data, st_resp} state;

  logic [sram_addr_width-1:0] addr;
  logic [7:0]                 beats_left;
  logic [axi_id_width-1:0]    id;
  logic                       beat_done;
  logic                       last_beat;

  assign beat_done = cmd.valid && cmd.ready;

  // The burst also closes when the AW length runs out, even without wlast
  assign last_beat = wlast || (beats_left == 8'd0);

  assign wready = (state == st_data) && cmd.ready;
  assign bvalid = (state == st_resp);
  assign bid    = id;
  assign bresp  = resp_okay;

  assign cmd.valid   = (state == st_data) && wvalid;
  assign cmd.addr    = addr;
  assign cmd.wr_data = wdata;
  assign cmd.wr_strb = wstrb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      awready <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (awvalid && awready) begin
            state   <= st_data;
            awready <= 1'b0;
          end else begin
            awready <= 1'b1;
          end
        end
        st_data: begin
          if (beat_done && last_beat) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (bready) begin
            state   <= st_idle;
            awready <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Byte address becomes a word address here, then steps once per beat
  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      addr       <= awaddr[axi_addr_width-1:word_lsb];
      beats_left <= awlen;
      id         <= awid;
    end else if (beat_done) begin
      addr       <= addr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

endmodule

// ==== axi_sram_rd.sv ====
module axi_sram_rd import axi_sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      arvalid,
  input  logic [axi_id_width-1:0]   arid,
  input  logic [axi_addr_width-1:0] araddr,
  input  logic [7:0]                arlen,
  output logic                      arready,

  output logic                      rvalid,
  output logic [axi_id_width-1:0]   rid,
  output logic [axi_data_width-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rlast,
  input  logic                      rready,

  sram_cmd_if.initiator             cmd,
  sram_rsp_if.sink                  rsp
);

  logic                       active;
  logic [sram_addr_width-1:0] addr;
  logic [7:0]                 beats_left;
  logic [axi_id_width-1:0]    id;
  logic                       cmd_done;

  assign cmd_done = cmd.valid && cmd.ready;

  assign cmd.valid = active;
  assign cmd.addr  = addr;
  assign cmd.meta  = id;
  assign cmd.last  = (beats_left == 8'd0);

  // Responses go straight out as R beats
  // A stalled rready holds the memory slot, which in turn stops new commands
  assign rvalid    = rsp.valid;
  assign rdata     = rsp.data;
  assign rid       = rsp.meta;
  assign rlast     = rsp.last;
  assign rresp     = resp_okay;
  assign rsp.ready = rready;

  // A new AR can be taken once the last command of the burst is out,
  // while its responses may still be in flight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active  <= 1'b0;
      arready <= 1'b0;
    end else if (arvalid && arready) begin
      active  <= 1'b1;
      arready <= 1'b0;
    end else if (cmd_done && cmd.last) begin
      active  <= 1'b0;
      arready <= 1'b1;
    end else begin
      arready <= !active;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      addr       <= araddr[axi_addr_width-1:word_lsb];
      beats_left <= arlen;
      id         <= arid;
    end else if (cmd_done) begin
      addr       <= addr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

endmodule

// ==== axi_sram_bridge.sv ====
module axi_sram_bridge import axi_sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      awvalid,
  input  logic [axi_id_width-1:0]   awid,
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic [7:0]                awlen,
  output logic                      awready,
  input  logic                      wvalid,
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  input  logic                      wlast,
  output logic                      wready,
  output logic                      bvalid,
  output logic [axi_id_width-1:0]   bid,
  output logic [1:0]                bresp,
  input  logic                      bready,

  input  logic                      arvalid,
  input  logic [axi_id_width-1:0]   arid,
  input  logic [axi_addr_width-1:0] araddr,
  input  logic [7:0]                arlen,
  output logic                      arready,
  output logic                      rvalid,
  output logic [axi_id_width-1:0]   rid,
  output logic [axi_data_width-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rlast,
  input  logic                      rready,

  sram_cmd_if.initiator             mem,
  sram_rsp_if.sink                  rsp
);

  enum logic [1:0] {st_idle, st_read, st_write} state, state_next;

  logic rsp_last_done;

  sram_cmd_if wr_cmd ();
  sram_cmd_if rd_cmd ();

  axi_sram_wr i_axi_sram_wr (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awready (awready),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wready  (wready),
    .bvalid  (bvalid),
    .bid     (bid),
    .bresp   (bresp),
    .bready  (bready),
    .cmd     (wr_cmd)
  );

  axi_sram_rd i_axi_sram_rd (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (arvalid),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arready (arready),
    .rvalid  (rvalid),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rready  (rready),
    .cmd     (rd_cmd),
    .rsp     (rsp)
  );

  assign rsp_last_done = rsp.valid && rsp.ready && rsp.last;

  // Reads win from idle and after every write beat, writes win after
  // every read burst, so neither side can starve the other
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (rd_cmd.valid) begin
          state_next = st_read;
        end else if (wr_cmd.valid) begin
          state_next = st_write;
        end
      end
      st_read: begin
        if (rsp_last_done) begin
          if (wr_cmd.valid) begin
            state_next = st_write;
          end else if (rd_cmd.valid) begin
            state_next = st_read;
          end else begin
            state_next = st_idle;
          end
        end
      end
      st_write: begin
        if (mem.ready) begin
          if (rd_cmd.valid) begin
            state_next = st_read;
          end else if (wr_cmd.valid) begin
            state_next = st_write;
          end else begin
            state_next = st_idle;
          end
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // The port follows the next grant so a handover costs no cycle
  always_comb begin
    mem.valid    = 1'b0;
    mem.wr_en    = 1'b0;
    mem.addr     = '0;
    mem.meta     = '0;
    mem.last     = 1'b0;
    rd_cmd.ready = 1'b0;
    wr_cmd.ready = 1'b0;
    case (state_next)
      st_read: begin
        mem.valid    = rd_cmd.valid;
        mem.addr     = rd_cmd.addr;
        mem.meta     = rd_cmd.meta;
        mem.last     = rd_cmd.last;
        rd_cmd.ready = mem.ready;
      end
      st_write: begin
        mem.valid    = wr_cmd.valid;
        mem.wr_en    = 1'b1;
        mem.addr     = wr_cmd.addr;
        wr_cmd.ready = mem.ready;
      end
      default: begin
      end
    endcase
  end

  // Write payload only matters when wr_en is set
  assign mem.wr_data = wr_cmd.wr_data;
  assign mem.wr_strb = wr_cmd.wr_strb;

endmodule

// ==== sram_mem.sv ====
module sram_mem import axi_sram_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  sram_cmd_if.target cmd,
  sram_rsp_if.source rsp
);

  logic [axi_data_width-1:0] mem [mem_depth];
  logic                      slot_valid;
  logic                      accept;
  logic                      rd_accept;

  assign accept    = cmd.valid && cmd.ready;
  assign rd_accept = accept && !cmd.wr_en;

  // The slot takes a new read in the same cycle its old one drains
  assign cmd.ready = !slot_valid || rsp.ready;
  assign rsp.valid = slot_valid;

  always_ff @(posedge clk) begin
    if (accept && cmd.wr_en) begin
      for (int b = 0; b < axi_strb_width; b++) begin
        if (cmd.wr_strb[b]) begin
          mem[cmd.addr][8*b +: 8] <= cmd.wr_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rsp.data <= mem[cmd.addr];
      rsp.meta <= cmd.meta;
      rsp.last <= cmd.last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
    end else if (rd_accept) begin
      slot_valid <= 1'b1;
    end else if (rsp.ready) begin
      slot_valid <= 1'b0;
    end
  end

endmodule

// ==== axi_sram_top.sv ====
module axi_sram_top import axi_sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      awvalid,
  input  logic [axi_id_width-1:0]   awid,
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic [7:0]                awlen,
  output logic                      awready,
  input  logic                      wvalid,
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  input  logic                      wlast,
  output logic                      wready,
  output logic                      bvalid,
  output logic [axi_id_width-1:0]   bid,
  output logic [1:0]                bresp,
  input  logic                      bready,

  input  logic                      arvalid,
  input  logic [axi_id_width-1:0]   arid,
  input  logic [axi_addr_width-1:0] araddr,
  input  logic [7:0]                arlen,
  output logic                      arready,
  output logic                      rvalid,
  output logic [axi_id_width-1:0]   rid,
  output logic [axi_data_width-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rlast,
  input  logic                      rready
);

  sram_cmd_if mem_cmd ();
  sram_rsp_if mem_rsp ();

  axi_sram_bridge i_axi_sram_bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awready (awready),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wready  (wready),
    .bvalid  (bvalid),
    .bid     (bid),
    .bresp   (bresp),
    .bready  (bready),
    .arvalid (arvalid),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arready (arready),
    .rvalid  (rvalid),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rready  (rready),
    .mem     (mem_cmd),
    .rsp     (mem_rsp)
  );

  sram_mem i_sram_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (mem_cmd),
    .rsp   (mem_rsp)
  );

endmodule

// ==== tb_axi_sram_assert.sv ====
module axi_sram_assert import axi_sram_pkg::*; (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      rvalid,
  input logic                      rready,
  input logic [axi_data_width-1:0] rdata,
  input logic [axi_id_width-1:0]   rid,
  input logic                      rlast,
  input logic                      bvalid,
  input logic                      bready,
  input logic [axi_id_width-1:0]   bid
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;

  // A stalled R beat keeps its payload
  r_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
  else begin
    $error("R beat changed while stalled");
    fails++;
  end

  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bid))
  else begin
    $error("B response dropped or changed before bready");
    fails++;
  end

  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rvalid && !bvalid)
  else begin
    $error("valid output high right after reset");
    fails++;
  end

endmodule

bind axi_sram_top axi_sram_assert i_axi_sram_assert (.*);

// ==== tb_axi_sram.sv ====
module tb_axi_sram import axi_sram_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 500;
  localparam int num_txns = 14;

  typedef struct packed {
    logic                      is_read;
    logic [axi_id_width-1:0]   id;
    logic [axi_addr_width-1:0] addr;
    logic [7:0]                len;
    logic [axi_data_width-1:0] seed;
    logic [axi_strb_width-1:0] strb;
    logic                      conc;
  } txn_t;

  logic                      clk;
  logic                      rst_n;
  logic                      awvalid;
  logic [axi_id_width-1:0]   awid;
  logic [axi_addr_width-1:0] awaddr;
  logic [7:0]                awlen;
  logic                      awready;
  logic                      wvalid;
  logic [axi_data_width-1:0] wdata;
  logic [axi_strb_width-1:0] wstrb;
  logic                      wlast;
  logic                      wready;
  logic                      bvalid;
  logic [axi_id_width-1:0]   bid;
  logic [1:0]                bresp;
  logic                      bready;
  logic                      arvalid;
  logic [axi_id_width-1:0]   arid;
  logic [axi_addr_width-1:0] araddr;
  logic [7:0]                arlen;
  logic                      arready;
  logic                      rvalid;
  logic [axi_id_width-1:0]   rid;
  logic [axi_data_width-1:0] rdata;
  logic [1:0]                rresp;
  logic                      rlast;
  logic                      rready;

  logic [axi_data_width-1:0] ref_mem [mem_depth];
  logic [31:0]               rng = 32'd2706;
  logic                      bp_on = 1'b0;

  // A concurrent read goes to addr ^ 0x800 with id + 1, which an earlier entry has written
  txn_t txns [num_txns] = '{
    '{1'b0, 4'd3,  12'h010, 8'd0, 16'ha5c3, 2'b11, 1'b0},
    '{1'b1, 4'd3,  12'h010, 8'd0, 16'h0000, 2'b00, 1'b0},
    '{1'b0, 4'd5,  12'h100, 8'd3, 16'h1234, 2'b11, 1'b0},
    '{1'b1, 4'd6,  12'h100, 8'd3, 16'h0000, 2'b00, 1'b0},
    '{1'b0, 4'd7,  12'h102, 8'd1, 16'h00ff, 2'b01, 1'b0},
    '{1'b0, 4'd8,  12'h104, 8'd0, 16'hbeef, 2'b10, 1'b0},
    '{1'b1, 4'd9,  12'h100, 8'd3, 16'h0000, 2'b00, 1'b0},
    '{1'b0, 4'd10, 12'h900, 8'd7, 16'h5555, 2'b11, 1'b0},
    '{1'b0, 4'd11, 12'h100, 8'd7, 16'h7a01, 2'b11, 1'b1},
    '{1'b1, 4'd13, 12'h100, 8'd7, 16'h0000, 2'b00, 1'b0},
    '{1'b0, 4'd14, 12'h010, 8'd0, 16'h0f0f, 2'b01, 1'b0},
    '{1'b1, 4'd15, 12'h010, 8'd0, 16'h0000, 2'b00, 1'b0},
    '{1'b0, 4'd0,  12'h904, 8'd3, 16'hc001, 2'b11, 1'b1},
    '{1'b1, 4'd2,  12'h900, 8'd7, 16'h0000, 2'b00, 1'b0}
  };

  axi_sram_top i_axi_sram_top (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready back-pressure on R and B
  always @(negedge clk) begin
    if (bp_on) begin
      rng = xorshift32(rng);
      rready = rng[3];
      bready = rng[11];
    end else begin
      rready = 1'b1;
      bready = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (i_axi_sram_top.i_axi_sram_assert.fails != 0) begin
      $display("a protocol assertion failed");
      $display("CHECKS FAILED");
      $fatal(1, "stopped on assertion failure");
    end
  end

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", wait_limit, what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic write_burst(input logic [axi_id_width-1:0] id,
                             input logic [axi_addr_width-1:0] addr, input logic [7:0] len,
                             input logic [axi_data_width-1:0] seed,
                             input logic [axi_strb_width-1:0] strb);
    logic [axi_data_width-1:0] data;
    int                        word;
    int                        cycles;
    @(negedge clk);
    awvalid = 1'b1;
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    cycles  = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("awready");
    end while (!awready);
    @(negedge clk);
    awvalid = 1'b0;
    for (int b = 0; b <= len; b++) begin
      data   = seed + axi_data_width'(b) * 16'h0101;
      wvalid = 1'b1;
      wdata  = data;
      wstrb  = strb;
      wlast  = (b == len);
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
        if (cycles > wait_limit) stop_on_timeout("wready");
      end while (!wready);
      word = int'(addr >> word_lsb) + b;
      for (int k = 0; k < axi_strb_width; k++) begin
        if (strb[k]) ref_mem[word][8*k +: 8] = data[8*k +: 8];
      end
      @(negedge clk);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("the B response");
    end while (!(bvalid && bready));
    check_equal("bid", bid, id);
    check_equal("bresp", bresp, 2'b00);
    // A second B for the same burst would show up here
    @(posedge clk);
    check_equal("bvalid", bvalid, 1'b0);
  endtask

  task automatic read_burst(input logic [axi_id_width-1:0] id,
                            input logic [axi_addr_width-1:0] addr, input logic [7:0] len);
    int word;
    int cycles;
    @(negedge clk);
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    arlen   = len;
    cycles  = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) stop_on_timeout("arready");
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    for (int b = 0; b <= len; b++) begin
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
        if (cycles > wait_limit) stop_on_timeout("an R beat");
      end while (!(rvalid && rready));
      word = int'(addr >> word_lsb) + b;
      check_equal("rdata", rdata, ref_mem[word]);
      check_equal("rid", rid, id);
      check_equal("rresp", rresp, 2'b00);
      check_equal("rlast", rlast, b == len);
    end
    @(posedge clk);
    check_equal("rvalid", rvalid, 1'b0);
  endtask

  initial begin
    txn_t                      t;
    logic [axi_data_width-1:0] seed;
    clk     = 1'b0;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b1;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    rready  = 1'b1;
    repeat (16) @(negedge clk);
    check_equal("awready", awready, 1'b0);
    check_equal("wready", wready, 1'b0);
    check_equal("arready", arready, 1'b0);
    check_equal("bvalid", bvalid, 1'b0);
    check_equal("rvalid", rvalid, 1'b0);
    rst_n = 1'b1;
    // Second pass repeats the table with inverted data and random ready
    for (int pass = 0; pass < 2; pass++) begin
      bp_on = (pass == 1);
      for (int i = 0; i < num_txns; i++) begin
        t    = txns[i];
        seed = t.seed ^ {axi_data_width{bp_on}};
        if (t.is_read) begin
          read_burst(t.id, t.addr, t.len);
        end else if (t.conc) begin
          fork
            write_burst(t.id, t.addr, t.len, seed, t.strb);
            read_burst(t.id + 1'b1, t.addr ^ 12'h800, t.len);
          join
        end else begin
          write_burst(t.id, t.addr, t.len, seed, t.strb);
        end
      end
    end
    if (i_axi_sram_top.i_axi_sram_assert.fails == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("a protocol assertion failed");
      $display("CHECKS FAILED");
      $fatal(1, "assertion failures at end of run");
    end
  end

endmodule

// ==== project.f ====
axi_sram_pkg.sv
sram_cmd_if.sv
axi_sram_wr.sv
axi_sram_rd.sv
axi_sram_bridge.sv
sram_mem.sv
axi_sram_top.sv
tb_axi_sram_assert.sv
tb_axi_sram.sv

// ==== Bender.yml ====
package:
  name: axi_sram

sources:
  - axi_sram_pkg.sv
  - sram_cmd_if.sv
  - axi_sram_wr.sv
  - axi_sram_rd.sv
  - axi_sram_bridge.sv
  - sram_mem.sv
  - axi_sram_top.sv
  - target: test
    files:
      - tb_axi_sram_assert.sv
      - tb_axi_sram.sv
